// ==== fetch.f ====
fetchPkg.sv
instCache.sv
branchTargetBuffer.sv
branchPredictor.sv
returnStack.sv
fetchStage.sv
fetchTop.sv
tbFetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbFetch -f fetch.f -o simFetch
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/simFetch 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// ==== tbFetch.sv ====
`timescale 1ns/10ps
// Testbench for the superscalar fetch top level
// directed tests over cache refill, predictors, stall and redirect
// a memory model answers each four-phase refill after a random delay

module tbFetch;

  logic clk, reset, stall, redirect, updateEn, updateTaken;
  logic [31:0] redirectPc, updatePc, updateTarget;
  logic [fetchPkg::CtrlTypeWidth-1:0] updateType;
  logic memReq, memAck, fetchValid, predTaken;
  logic [31:0] memAddr, fetchPc, predTarget;
  logic [fetchPkg::BundleWidth-1:0] memData, bundle;
  logic [fetchPkg::FetchWidth-1:0] slotMask;

  int seed = 24;
  int memState;             // 0 idle, 1 counting delay, 2 ack high
  int memDelay;
  int memWait;
  logic [31:0] memLine;     // address captured with the request

  fetchTop DUT (
    .clk(clk), .reset(reset), .stall_i(stall), .redirect_i(redirect), .redirectPc_i(redirectPc),
    .updateEn_i(updateEn), .updatePc_i(updatePc), .updateTarget_i(updateTarget),
    .updateType_i(updateType), .updateTaken_i(updateTaken),
    .memReq_o(memReq), .memAddr_o(memAddr), .memAck_i(memAck), .memData_i(memData),
    .fetchValid_o(fetchValid), .fetchPc_o(fetchPc), .bundle_o(bundle), .slotMask_o(slotMask),
    .predTaken_o(predTaken), .predTarget_o(predTarget)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // reference model
  // each memory word is its word address * 3 + 1
  function automatic logic [fetchPkg::BundleWidth-1:0] expectedBundle(input logic [31:0] addr);
    logic [fetchPkg::BundleWidth-1:0] line;
    logic [31:0] wordAddr;
    line = '0;
    for (int i = 0; i < fetchPkg::FetchWidth; i++) begin
      wordAddr = {2'b00, addr[31:4], 2'(i)};
      line[i*32 +: 32] = wordAddr * 3 + 1;  // slot 0 in the low word
    end
    return line;
  endfunction

  ////////////////////
  // reporting
  task automatic abortRun();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic reportProblem(input string what);
    $display("ERROR at %0t: %s", $time, what);
    abortRun();
  endtask

  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkFetch(input logic [31:0] expPc, input logic [3:0] expMask,
                            input logic expTaken, input logic [31:0] expNext);
    checkValue("fetchPc_o", expPc, fetchPc);
    checkValue("bundle_o", expectedBundle(expPc), bundle);
    checkValue("slotMask_o", expMask, slotMask);
    checkValue("predTaken_o", expTaken, predTaken);
    checkValue("predTarget_o", expNext, predTarget);
  endtask

  ////////////////////
  // drive and wait helpers
  // inputs move 2 ns after the edge and outputs are read at negedge
  task automatic afterEdge();
    @(posedge clk);
    #2;
  endtask

  task automatic waitValid();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!fetchValid) begin
      cycles++;
      if (cycles > 40) reportProblem("no valid fetch within 40 cycles");
      @(negedge clk);
    end
  endtask

  task automatic waitMemReq(input logic [31:0] addr);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!(memReq && memAddr == addr)) begin
      cycles++;
      if (cycles > 40) reportProblem("expected refill request never appeared");
      @(negedge clk);
    end
  endtask

  task automatic sendUpdate(input logic [31:0] pc, input logic [31:0] target,
                            input logic [1:0] kind, input logic taken);
    afterEdge();
    updateEn = 1'b1;
    updatePc = pc;
    updateTarget = target;
    updateType = kind;
    updateTaken = taken;
    afterEdge();
    updateEn = 1'b0;
  endtask

  task automatic redirectTo(input logic [31:0] addr, input logic holdStall);
    afterEdge();
    redirect = 1'b1;
    redirectPc = addr;
    stall = holdStall;
    afterEdge();
    redirect = 1'b0;
  endtask

  task automatic setStall(input logic value);
    afterEdge();
    stall = value;
  endtask

  // one step of the four-phase memory side per cycle
  task automatic serviceMemory();
    case (memState)
      0: begin
        if (memReq) begin
          if (memAddr[3:0] != 4'h0) reportProblem("refill address is not line aligned");
          memLine = memAddr;
          memDelay = 1 + ($unsigned($random(seed)) % 4);  // 1..4 cycles
          memState = 1;
        end
      end
      1: begin
        if (!memReq) reportProblem("request dropped before the acknowledge");
        checkValue("memAddr_o", memLine, memAddr);  // held while req is high
        memDelay--;
        if (memDelay == 0) begin
          memAck = 1'b1;
          memData = expectedBundle(memLine);
          memWait = 0;
          memState = 2;
        end
      end
      default: begin
        if (!memReq) begin
          memAck = 1'b0;
          memState = 0;
        end else begin
          memWait++;
          if (memWait > 4) reportProblem("request still high after the acknowledge");
        end
      end
    endcase
  endtask

  initial begin
    memState = 0;
    memAck = 1'b0;
    memData = '0;
    forever begin
      afterEdge();
      serviceMemory();
    end
  end

  ////////////////////
  // directed tests
  task automatic coldMiss();
    @(negedge clk);
    checkValue("fetchValid_o", 1'b0, fetchValid);
    checkValue("memReq_o", 1'b0, memReq);
    checkValue("fetchPc_o", 32'h0, fetchPc);
    waitMemReq(32'h0);
    waitValid();
    checkFetch(32'h0, 4'b1111, 1'b0, 32'h10);
  endtask

  task automatic sequentialFetch();
    logic [31:0] expPc;
    expPc = 32'h0;
    for (int i = 0; i < 6; i++) begin
      expPc = expPc + 32'd16;  // next bundle in line order
      waitValid();
      checkFetch(expPc, 4'b1111, 1'b0, expPc + 32'd16);
    end
  endtask

  // conditional at 0x804 toward 0x900
  task automatic condRound(input logic followed);
    redirectTo(32'h800, 1'b0);
    waitValid();
    if (followed) begin
      checkFetch(32'h800, 4'b0011, 1'b1, 32'h900);
    end else begin
      checkFetch(32'h800, 4'b1111, 1'b0, 32'h810);
    end
    waitValid();
    checkValue("fetchPc_o", followed ? 32'h900 : 32'h810, fetchPc);
  endtask

  task automatic jumpAndBranch();
    setStall(1'b1);
    sendUpdate(32'h408, 32'h600, fetchPkg::CtrlJump, 1'b1);  // jump in slot 2
    redirectTo(32'h400, 1'b0);
    waitValid();
    checkFetch(32'h400, 4'b0111, 1'b1, 32'h600);
    waitValid();
    checkFetch(32'h600, 4'b1111, 1'b0, 32'h610);
    // a not-taken outcome first drops the counter to 0
    setStall(1'b1);
    sendUpdate(32'h804, 32'h900, fetchPkg::CtrlCond, 1'b0);
    sendUpdate(32'h804, 32'h900, fetchPkg::CtrlCond, 1'b1);
    condRound(1'b0);                                          // one taken, still not followed
    setStall(1'b1);
    sendUpdate(32'h804, 32'h900, fetchPkg::CtrlCond, 1'b1);
    condRound(1'b1);                                          // second taken, now followed
  endtask

  task automatic callReturn();
    setStall(1'b1);
    sendUpdate(32'hC14, 32'hD40, fetchPkg::CtrlCall, 1'b1);    // call in slot 1
    sendUpdate(32'hD4C, 32'h0, fetchPkg::CtrlReturn, 1'b1);    // return in slot 3
    redirectTo(32'hC10, 1'b0);
    waitValid();
    checkFetch(32'hC10, 4'b0011, 1'b1, 32'hD40);
    waitValid();
    checkFetch(32'hD40, 4'b1111, 1'b1, 32'hC18);               // call address plus 4
    waitValid();
    checkFetch(32'hC18, 4'b1100, 1'b0, 32'hC20);
  endtask

  task automatic redirectStall();
    redirectTo(32'h2000, 1'b0);
    waitMemReq(32'h2000);
    redirectTo(32'h1008, 1'b1);  // lands mid refill and holds the fetch
    waitValid();
    checkFetch(32'h1008, 4'b1100, 1'b0, 32'h1010);
    repeat (4) begin
      @(negedge clk);
      checkValue("fetchValid_o", 1'b1, fetchValid);
      checkFetch(32'h1008, 4'b1100, 1'b0, 32'h1010);
    end
    setStall(1'b0);
    waitValid();
    checkValue("fetchPc_o", 32'h1008, fetchPc);  // held bundle consumed at the next edge
    waitValid();
    checkFetch(32'h1010, 4'b1111, 1'b0, 32'h1020);
  endtask

  initial begin
    reset = 1'b1;
    stall = 1'b0;
    redirect = 1'b0;
    redirectPc = '0;
    updateEn = 1'b0;
    updatePc = '0;
    updateTarget = '0;
    updateType = fetchPkg::CtrlJump;
    updateTaken = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    coldMiss();
    sequentialFetch();
    jumpAndBranch();
    callReturn();
    redirectStall();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== fetchTop.sv ====
`timescale 1ns/10ps
// Superscalar fetch top, four instructions per cycle from the instruction cache
// next bundle predicted by the target buffer, counters and return stack

module fetchTop (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                stall_i,
  input  logic                                redirect_i,
  input  logic [fetchPkg::PcWidth-1:0]        redirectPc_i,
  // training from the back end, in program order
  input  logic                                updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]        updatePc_i,
  input  logic [fetchPkg::PcWidth-1:0]        updateTarget_i,
  input  logic [fetchPkg::CtrlTypeWidth-1:0]  updateType_i,
  input  logic                                updateTaken_i,
  // refill side
  output logic                                memReq_o,
  output logic [fetchPkg::PcWidth-1:0]        memAddr_o,
  input  logic                                memAck_i,
  input  logic [fetchPkg::BundleWidth-1:0]    memData_i,
  // fetched bundle
  output logic                                fetchValid_o,
  output logic [fetchPkg::PcWidth-1:0]        fetchPc_o,
  output logic [fetchPkg::BundleWidth-1:0]    bundle_o,
  output logic [fetchPkg::FetchWidth-1:0]     slotMask_o,
  output logic                                predTaken_o,
  output logic [fetchPkg::PcWidth-1:0]        predTarget_o
);

  logic [fetchPkg::PcWidth-1:0]                            pc;
  logic                                                    cacheHit;
  logic [fetchPkg::FetchWidth-1:0]                         btbHit;
  logic [fetchPkg::FetchWidth*fetchPkg::CtrlTypeWidth-1:0] btbType;
  logic [fetchPkg::FetchWidth*fetchPkg::PcWidth-1:0]       btbTarget;
  logic [fetchPkg::FetchWidth-1:0]                         bpTaken;
  logic [fetchPkg::PcWidth-1:0]                            rasTop;
  logic                                                    rasPush;
  logic                                                    rasPop;
  logic [fetchPkg::PcWidth-1:0]                            rasPushAddr;

  fetchStage stage (
    .clk(clk), .reset(reset),
    .stall_i(stall_i), .redirect_i(redirect_i), .redirectPc_i(redirectPc_i),
    .cacheHit_i(cacheHit), .btbHit_i(btbHit), .btbType_i(btbType),
    .btbTarget_i(btbTarget), .bpTaken_i(bpTaken), .rasTop_i(rasTop),
    .rasPush_o(rasPush), .rasPop_o(rasPop), .rasPushAddr_o(rasPushAddr),
    .pc_o(pc), .fetchValid_o(fetchValid_o), .slotMask_o(slotMask_o),
    .predTaken_o(predTaken_o), .predTarget_o(predTarget_o)
  );

  instCache icache (
    .clk(clk), .reset(reset), .pc_i(pc), .hit_o(cacheHit), .bundle_o(bundle_o),
    .memReq_o(memReq_o), .memAddr_o(memAddr_o), .memAck_i(memAck_i), .memData_i(memData_i)
  );

  ////////////////////
  // predictors, all read the same fetch PC
  branchTargetBuffer btb (
    .clk(clk), .reset(reset), .pc_i(pc),
    .slotHit_o(btbHit), .slotType_o(btbType), .slotTarget_o(btbTarget),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i), .updateTarget_i(updateTarget_i),
    .updateType_i(updateType_i), .updateTaken_i(updateTaken_i)
  );

  branchPredictor bp (
    .clk(clk), .reset(reset), .pc_i(pc), .slotTaken_o(bpTaken),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i),
    .updateType_i(updateType_i), .updateTaken_i(updateTaken_i)
  );

  returnStack ras (
    .clk(clk), .reset(reset), .push_i(rasPush), .pop_i(rasPop),
    .pushAddr_i(rasPushAddr), .top_o(rasTop)
  );

  assign fetchPc_o = pc;

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/10ps
// Fetch control, holds the PC and picks the next bundle address
// qualifies slots from the target buffer and counters, drives the RAS strobes

module fetchStage (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   stall_i,
  input  logic                                                   redirect_i,
  input  logic [fetchPkg::PcWidth-1:0]                           redirectPc_i,
  input  logic                                                   cacheHit_i,
  input  logic [fetchPkg::FetchWidth-1:0]                        btbHit_i,
  input  logic [fetchPkg::FetchWidth*fetchPkg::CtrlTypeWidth-1:0] btbType_i,
  input  logic [fetchPkg::FetchWidth*fetchPkg::PcWidth-1:0]       btbTarget_i,
  input  logic [fetchPkg::FetchWidth-1:0]                        bpTaken_i,
  input  logic [fetchPkg::PcWidth-1:0]                           rasTop_i,
  output logic                                                   rasPush_o,
  output logic                                                   rasPop_o,
  output logic [fetchPkg::PcWidth-1:0]                           rasPushAddr_o,
  output logic [fetchPkg::PcWidth-1:0]                           pc_o,
  output logic                                                   fetchValid_o,
  output logic [fetchPkg::FetchWidth-1:0]                        slotMask_o,
  output logic                                                   predTaken_o,
  output logic [fetchPkg::PcWidth-1:0]                           predTarget_o
);

  logic [fetchPkg::PcWidth-1:0]       pcReg;
  logic [fetchPkg::PcWidth-1:0]       alignedPc;
  logic [fetchPkg::PcWidth-1:0]       takenTarget;
  logic [fetchPkg::PcWidth-1:0]       nextPc;
  logic [fetchPkg::FetchWidth-1:0]    slotTaken;   // qualified control slots
  logic                               takenAny;
  logic [1:0]                         takenIdx;    // first taken slot
  logic [fetchPkg::CtrlTypeWidth-1:0] takenType;
  logic                               advance;     // bundle consumed this cycle

  assign alignedPc = {pcReg[fetchPkg::PcWidth-1:4], 4'b0000};

  ////////////////////
  // slot qualification
  // slots before the PC offset are not part of this fetch
  always_comb begin
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      slotTaken[s] = (2'(s) >= pcReg[3:2]) && btbHit_i[s] &&
          ((btbType_i[s*fetchPkg::CtrlTypeWidth +: fetchPkg::CtrlTypeWidth] !=
            fetchPkg::CtrlCond) || bpTaken_i[s]);
    end
  end

  // lowest taken slot wins, scan from the top so the last hit stays
  always_comb begin
    takenAny = 1'b0;
    takenIdx = 2'd0;
    for (int s = fetchPkg::FetchWidth - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        takenAny = 1'b1;
        takenIdx = 2'(s);
      end
    end
  end

  assign takenType = btbType_i[takenIdx*fetchPkg::CtrlTypeWidth +: fetchPkg::CtrlTypeWidth];

  ////////////////////
  // next PC
  assign takenTarget = (takenType == fetchPkg::CtrlReturn) ? rasTop_i
                     : btbTarget_i[takenIdx*fetchPkg::PcWidth +: fetchPkg::PcWidth];
  assign nextPc = takenAny ? takenTarget
                           : alignedPc + fetchPkg::BundleBytes;  // fall through

  // valid slots run from the offset through the taken slot
  always_comb begin
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      slotMask_o[s] = (2'(s) >= pcReg[3:2]) && (!takenAny || (2'(s) <= takenIdx));
    end
  end

  assign fetchValid_o = cacheHit_i && !redirect_i;  // redirected bundle is dropped
  assign advance      = fetchValid_o && !stall_i;

  ////////////////////
  // RAS control, only on a consumed bundle
  assign rasPush_o     = advance && takenAny && (takenType == fetchPkg::CtrlCall);
  assign rasPop_o      = advance && takenAny && (takenType == fetchPkg::CtrlReturn);
  assign rasPushAddr_o = {pcReg[fetchPkg::PcWidth-1:4], takenIdx, 2'b00}
                       + (fetchPkg::InstWidth / 8);  // return lands after the call

  // PC register, redirect beats everything
  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (redirect_i) begin
      pcReg <= redirectPc_i;
    end else if (cacheHit_i && !stall_i) begin
      pcReg <= nextPc;
    end
  end

  assign pc_o         = pcReg;
  assign predTaken_o  = takenAny;
  assign predTarget_o = nextPc;  // predicted address of the next bundle

endmodule

// ==== returnStack.sv ====
`timescale 1ns/10ps
// Return address stack, circular, overflow drops the oldest entry

module returnStack (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push_i,      // never together with pop_i
  input  logic                         pop_i,
  input  logic [fetchPkg::PcWidth-1:0] pushAddr_i,
  output logic [fetchPkg::PcWidth-1:0] top_o
);

  logic [fetchPkg::PcWidth-1:0]    stackMem [fetchPkg::RasDepth];
  logic [fetchPkg::RasPtrBits-1:0] ptr;     // next free entry
  logic [fetchPkg::RasPtrBits-1:0] topPtr;  // most recent push

  assign topPtr = ptr - 1'b1;  // wraps, so an empty pop reads stale data
  assign top_o  = stackMem[topPtr];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (push_i) begin
      ptr <= ptr + 1'b1;
    end else if (pop_i) begin
      ptr <= topPtr;
    end
  end

  // entries themselves
  always_ff @(posedge clk) begin
    if (push_i) begin
      stackMem[ptr] <= pushAddr_i;
    end
  end

endmodule

// ==== branchPredictor.sv ====
`timescale 1ns/10ps
// Direction predictor, a table of two-bit saturating counters
// indexed by word address, one taken bit per bundle slot

module branchPredictor (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [fetchPkg::PcWidth-1:0]        pc_i,
  output logic [fetchPkg::FetchWidth-1:0]     slotTaken_o,
  input  logic                                updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]        updatePc_i,
  input  logic [fetchPkg::CtrlTypeWidth-1:0]  updateType_i,
  input  logic                                updateTaken_i
);

  logic [1:0] counters [fetchPkg::BpEntries];
  logic [$clog2(fetchPkg::BpEntries)-1:0] updateIndex;
  logic                                   trainEn;

  // lookup, upper counter bit is the prediction
  for (genvar s = 0; s < fetchPkg::FetchWidth; s++) begin : gSlot
    logic [$clog2(fetchPkg::BpEntries)-1:0] slotIndex;
    assign slotIndex      = {pc_i[$clog2(fetchPkg::BpEntries)+1:4], 2'(s)};
    assign slotTaken_o[s] = counters[slotIndex][1];
  end

  assign trainEn     = updateEn_i && (updateType_i == fetchPkg::CtrlCond);  // cond only
  assign updateIndex = updatePc_i[$clog2(fetchPkg::BpEntries)+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fetchPkg::BpEntries; i++) begin
        counters[i] <= fetchPkg::CounterInit;
      end
    end else if (trainEn) begin
      if (updateTaken_i && (counters[updateIndex] != 2'b11)) begin
        counters[updateIndex] <= counters[updateIndex] + 2'd1;  // step toward taken
      end else if (!updateTaken_i && (counters[updateIndex] != 2'b00)) begin
        counters[updateIndex] <= counters[updateIndex] - 2'd1;
      end
    end
  end

endmodule

// ==== branchTargetBuffer.sv ====
`timescale 1ns/10ps
// Branch target buffer, direct mapped on the instruction word address
// four lookups per cycle, one for each slot of the fetch bundle

module branchTargetBuffer (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic [fetchPkg::PcWidth-1:0]                           pc_i,
  output logic [fetchPkg::FetchWidth-1:0]                        slotHit_o,
  output logic [fetchPkg::FetchWidth*fetchPkg::CtrlTypeWidth-1:0] slotType_o,
  output logic [fetchPkg::FetchWidth*fetchPkg::PcWidth-1:0]       slotTarget_o,
  input  logic                                                   updateEn_i,
  input  logic [fetchPkg::PcWidth-1:0]                           updatePc_i,
  input  logic [fetchPkg::PcWidth-1:0]                           updateTarget_i,
  input  logic [fetchPkg::CtrlTypeWidth-1:0]                     updateType_i,
  input  logic                                                   updateTaken_i
);

  // entry fields, tag is the PC above index and word offset
  logic [fetchPkg::PcWidth-fetchPkg::BtbIndexBits-3:0] tagArray [fetchPkg::BtbEntries];
  logic [fetchPkg::CtrlTypeWidth-1:0] typeArray   [fetchPkg::BtbEntries];
  logic [fetchPkg::PcWidth-1:0]       targetArray [fetchPkg::BtbEntries];
  logic [fetchPkg::BtbEntries-1:0]    validBits;

  logic [fetchPkg::BtbIndexBits-1:0] updateIndex;
  logic                              writeEn;

  ////////////////////
  // per-slot lookup
  for (genvar s = 0; s < fetchPkg::FetchWidth; s++) begin : gSlot
    logic [fetchPkg::PcWidth-1:0]      slotPc;
    logic [fetchPkg::BtbIndexBits-1:0] slotIndex;

    assign slotPc    = {pc_i[fetchPkg::PcWidth-1:4], 2'(s), 2'b00};  // word address of slot
    assign slotIndex = slotPc[fetchPkg::BtbIndexBits+1:2];

    assign slotHit_o[s] = validBits[slotIndex] &&
        (tagArray[slotIndex] == slotPc[fetchPkg::PcWidth-1:fetchPkg::BtbIndexBits+2]);
    assign slotType_o[s*fetchPkg::CtrlTypeWidth +: fetchPkg::CtrlTypeWidth] =
        typeArray[slotIndex];
    assign slotTarget_o[s*fetchPkg::PcWidth +: fetchPkg::PcWidth] = targetArray[slotIndex];
  end

  ////////////////////
  // training write
  // a not-taken conditional leaves the entry alone
  assign writeEn = updateEn_i &&
                   ((updateType_i != fetchPkg::CtrlCond) || updateTaken_i);
  assign updateIndex = updatePc_i[fetchPkg::BtbIndexBits+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
    end else if (writeEn) begin
      validBits[updateIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (writeEn) begin
      tagArray[updateIndex]    <= updatePc_i[fetchPkg::PcWidth-1:fetchPkg::BtbIndexBits+2];
      typeArray[updateIndex]   <= updateType_i;
      targetArray[updateIndex] <= updateTarget_i;  // overwrites an older branch on alias
    end
  end

endmodule

// ==== instCache.sv ====
`timescale 1ns/10ps
// Instruction cache, direct mapped, one aligned four-instruction bundle per line
// a miss refills the line from memory over a four-phase req/ack handshake

module instCache (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [fetchPkg::PcWidth-1:0]     pc_i,
  output logic                             hit_o,
  output logic [fetchPkg::BundleWidth-1:0] bundle_o,    // slot 0 in the low word
  output logic                             memReq_o,
  output logic [fetchPkg::PcWidth-1:0]     memAddr_o,   // line address, 16 byte aligned
  input  logic                             memAck_i,
  input  logic [fetchPkg::BundleWidth-1:0] memData_i
);

  // line arrays
  logic [fetchPkg::BundleWidth-1:0] dataArray [fetchPkg::CacheLines];
  logic [fetchPkg::PcWidth-fetchPkg::CacheIndexBits-5:0] tagArray [fetchPkg::CacheLines];
  logic [fetchPkg::CacheLines-1:0]  validBits;

  logic [fetchPkg::CacheIndexBits-1:0] pcIndex;     // bits 7:4
  logic [fetchPkg::CacheIndexBits-1:0] refillIndex;
  logic [fetchPkg::PcWidth-1:0]        refillAddr;  // held while memReq_o is high
  logic                                reqActive;   // request phase
  logic                                waitAckLow;  // line written, ack still high
  logic                                startRefill;
  logic                                ackSeen;

  assign pcIndex     = pc_i[fetchPkg::CacheIndexBits+3:4];
  assign refillIndex = refillAddr[fetchPkg::CacheIndexBits+3:4];

  ////////////////////
  // lookup, combinational in the PC's cycle
  assign hit_o = validBits[pcIndex] &&
                 (tagArray[pcIndex] == pc_i[fetchPkg::PcWidth-1:fetchPkg::CacheIndexBits+4]);
  assign bundle_o = dataArray[pcIndex];

  ////////////////////
  // refill FSM  idle -> request -> wait-ack-low -> idle
  assign startRefill = !reqActive && !waitAckLow && !hit_o;  // only from idle
  assign ackSeen     = reqActive && memAck_i;                // line arrives here

  always_ff @(posedge clk) begin
    if (reset) begin
      reqActive  <= 1'b0;
      waitAckLow <= 1'b0;
      validBits  <= '0;
    end else begin
      if (startRefill) begin
        reqActive <= 1'b1;           // memReq_o rises one edge after the miss
      end else if (ackSeen) begin
        reqActive  <= 1'b0;          // drop req in the same edge as the write
        waitAckLow <= 1'b1;
        validBits[refillIndex] <= 1'b1;
      end else if (waitAckLow && !memAck_i) begin
        waitAckLow <= 1'b0;          // handshake closed, may request again
      end
    end
  end

  // line payload and refill address
  always_ff @(posedge clk) begin
    if (startRefill) begin
      refillAddr <= {pc_i[fetchPkg::PcWidth-1:4], 4'b0000};  // aligned line
    end
    if (ackSeen) begin
      dataArray[refillIndex] <= memData_i;
      tagArray[refillIndex]  <= refillAddr[fetchPkg::PcWidth-1:fetchPkg::CacheIndexBits+4];
    end
  end

  assign memReq_o  = reqActive;
  assign memAddr_o = refillAddr;

endmodule

// ==== fetchPkg.sv ====
// Fetch stage shared definitions
// widths, table sizes and branch type codes used by every fetch block

package fetchPkg;

  ////////////////////
  // datapath widths
  localparam int PcWidth     = 32;
  localparam int InstWidth   = 32;
  localparam int FetchWidth  = 4;    // instructions per bundle
  localparam int BundleWidth = 128;  // FetchWidth * InstWidth
  localparam int BundleBytes = 16;

  ////////////////////
  // table sizes
  localparam int CacheLines     = 16;
  localparam int CacheIndexBits = 4;
  localparam int BtbEntries     = 64;
  localparam int BtbIndexBits   = 6;
  localparam int BpEntries      = 64;
  localparam int RasDepth       = 8;
  localparam int RasPtrBits     = 3;

  ////////////////////
  // control instruction types, as stored in the target buffer
  localparam int CtrlTypeWidth = 2;
  localparam logic [CtrlTypeWidth-1:0] CtrlReturn = 2'd0;
  localparam logic [CtrlTypeWidth-1:0] CtrlCall   = 2'd1;
  localparam logic [CtrlTypeWidth-1:0] CtrlJump   = 2'd2;
  localparam logic [CtrlTypeWidth-1:0] CtrlCond   = 2'd3;

  // counters come out of reset weakly not-taken
  localparam logic [1:0] CounterInit = 2'd1;

endpackage
